// ==== source/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_index_t;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;

	typedef logic [5:0] imem_address_t;
	typedef logic [5:0] dmem_address_t;

	// bit positions in the one-hot opcode vector.
	typedef enum int unsigned {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_lw,
		op_sw,
		op_addi,
		op_add
	} op_index_e;

	localparam int OP_COUNT = 9;

	typedef logic [OP_COUNT-1:0] opcode_vec_t;

	typedef struct packed {
		word_t instruction;
		word_t pc;
		word_t dnpc;
	} fetch_packet_t;

	typedef struct packed {
		opcode_vec_t opcode;
		logic [2:0] funct3;
		reg_index_t rd;
		word_t imm;
		logic reg_wen;
		word_t pc;
		word_t dnpc;
		word_t src1;
		word_t src2;
	} decoded_t;

	// the state of a later stage that decode forwards from.
	typedef struct packed {
		reg_index_t rd;
		logic reg_wen;
		logic load;
		logic busy;
		word_t value;
	} stage_status_t;

	typedef struct packed {
		opcode_vec_t opcode;
		reg_index_t rd;
		logic reg_wen;
		word_t result;
		word_t store_data;
	} memory_request_t;

	typedef struct packed {
		reg_index_t rd;
		logic reg_wen;
		word_t value;
	} retire_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input  logic clock,
	input  logic reset,
	input  logic run,
	input  logic imem_write,
	input  core_pkg::imem_address_t imem_address,
	input  core_pkg::word_t imem_data,
	input  logic redirect,
	input  core_pkg::word_t redirect_pc,
	input  logic fetch_ready,
	output logic fetch_valid,
	output core_pkg::fetch_packet_t fetch_packet
);

	core_pkg::word_t imem [core_pkg::IMEM_DEPTH];
	core_pkg::word_t pc;
	core_pkg::imem_address_t fetch_index;
	logic advance;

	// the program load port is only used while the core is stopped.
	always_ff @(posedge clock) begin
		if (imem_write) begin
			imem[imem_address] <= imem_data;
		end
	end

	assign fetch_index = core_pkg::imem_address_t'(pc >> 2);

	// the slot can take a new packet when it is empty or being handed over.
	assign advance = ~fetch_valid | fetch_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (redirect) begin
			pc <= redirect_pc;
			fetch_valid <= 1'b0;
		end else if (advance) begin
			fetch_valid <= run;
			if (run) begin
				pc <= pc + 32'd4;
			end
		end
	end

	// next pc is always predicted as pc+4.
	always_ff @(posedge clock) begin
		if (~redirect & advance & run) begin
			fetch_packet.instruction <= imem[fetch_index];
			fetch_packet.pc <= pc;
			fetch_packet.dnpc <= pc + 32'd4;
		end
	end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic clock,
	input  logic reset,
	input  core_pkg::reg_index_t rs1,
	input  core_pkg::reg_index_t rs2,
	output core_pkg::word_t src1,
	output core_pkg::word_t src2,
	input  logic write_enable,
	input  core_pkg::reg_index_t write_rd,
	input  core_pkg::word_t write_value
);

	core_pkg::word_t regs [16];

	// x0 is never written, so it keeps the zero from reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_rd != '0) begin
			regs[write_rd] <= write_value;
		end
	end

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
	input  logic clock,
	input  logic reset,
	input  logic fetch_valid,
	output logic fetch_ready,
	input  core_pkg::fetch_packet_t fetch_packet,
	output core_pkg::reg_index_t rs1,
	output core_pkg::reg_index_t rs2,
	input  core_pkg::word_t src1,
	input  core_pkg::word_t src2,
	input  core_pkg::stage_status_t exu_status,
	input  core_pkg::stage_status_t mem_status,
	input  logic redirect,
	output logic exu_valid,
	input  logic exu_ready,
	output core_pkg::decoded_t decoded
);

	core_pkg::word_t instruction;
	logic [4:0] opcode5;
	core_pkg::opcode_vec_t opcode;
	logic type_r;
	logic type_i;
	logic type_s;
	logic type_b;
	logic type_u;
	logic type_j;
	core_pkg::word_t imm;
	logic reg_wen;
	logic need_rs1;
	logic need_rs2;
	logic rs1_exu_hit;
	logic rs2_exu_hit;
	logic rs1_mem_hit;
	logic rs2_mem_hit;
	core_pkg::word_t src1_value;
	core_pkg::word_t src2_value;
	logic stall;
	logic slot_ready;
	logic accept;

	function automatic logic source_hit(
		input core_pkg::stage_status_t status,
		input core_pkg::reg_index_t index,
		input logic needed
	);
		return needed & status.busy & status.reg_wen & (status.rd != '0) & (status.rd == index);
	endfunction

	assign instruction = fetch_packet.instruction;
	assign opcode5 = instruction[6:2];
	assign rs1 = instruction[18:15];
	assign rs2 = instruction[23:20];

	assign opcode[core_pkg::op_lui] = (opcode5 == 5'b01101);
	assign opcode[core_pkg::op_auipc] = (opcode5 == 5'b00101);
	assign opcode[core_pkg::op_jal] = (opcode5 == 5'b11011);
	assign opcode[core_pkg::op_jalr] = (opcode5 == 5'b11001);
	assign opcode[core_pkg::op_beq] = (opcode5 == 5'b11000);
	assign opcode[core_pkg::op_lw] = (opcode5 == 5'b00000);
	assign opcode[core_pkg::op_sw] = (opcode5 == 5'b01000);
	assign opcode[core_pkg::op_addi] = (opcode5 == 5'b00100);
	assign opcode[core_pkg::op_add] = (opcode5 == 5'b01100);

	assign type_r = opcode[core_pkg::op_add];
	assign type_i = opcode[core_pkg::op_jalr] | opcode[core_pkg::op_lw] | opcode[core_pkg::op_addi];
	assign type_s = opcode[core_pkg::op_sw];
	assign type_b = opcode[core_pkg::op_beq];
	assign type_u = opcode[core_pkg::op_lui] | opcode[core_pkg::op_auipc];
	assign type_j = opcode[core_pkg::op_jal];

	always_comb begin
		if (type_i) begin
			imm = {{20{instruction[31]}}, instruction[31:20]};
		end else if (type_u) begin
			imm = {instruction[31:12], 12'b0};
		end else if (type_s) begin
			imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
		end else if (type_j) begin
			imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
				instruction[30:21], 1'b0};
		end else if (type_b) begin
			imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
				instruction[11:8], 1'b0};
		end else begin
			imm = '0;
		end
	end

	assign reg_wen = type_r | type_i | type_u | type_j;
	assign need_rs2 = type_b | type_s | type_r;
	assign need_rs1 = need_rs2 | type_i;

	// execute holds the younger result, so it wins over memory.
	assign rs1_exu_hit = source_hit(exu_status, rs1, need_rs1);
	assign rs2_exu_hit = source_hit(exu_status, rs2, need_rs2);
	assign rs1_mem_hit = source_hit(mem_status, rs1, need_rs1);
	assign rs2_mem_hit = source_hit(mem_status, rs2, need_rs2);

	assign src1_value = rs1_exu_hit ? exu_status.value :
		rs1_mem_hit ? mem_status.value : src1;
	assign src2_value = rs2_exu_hit ? exu_status.value :
		rs2_mem_hit ? mem_status.value : src2;

	// a load whose value is not there yet stalls its consumer.
	assign stall = (exu_status.load & (rs1_exu_hit | rs2_exu_hit)) |
		(mem_status.load & (rs1_mem_hit | rs2_mem_hit));

	assign fetch_ready = slot_ready & ~stall;
	assign accept = fetch_valid & fetch_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_ready <= 1'b1;
			exu_valid <= 1'b0;
		end else begin
			slot_ready <= redirect | (slot_ready & ~accept) | (~slot_ready & exu_valid & exu_ready);
			exu_valid <= ((exu_valid & ~exu_ready) | accept) & ~redirect;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			decoded.opcode <= opcode;
			decoded.funct3 <= instruction[14:12];
			decoded.rd <= instruction[10:7];
			decoded.imm <= imm;
			decoded.reg_wen <= reg_wen;
			decoded.pc <= fetch_packet.pc;
			decoded.dnpc <= fetch_packet.dnpc;
			decoded.src1 <= src1_value;
			decoded.src2 <= src2_value;
		end
	end

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
	input  logic clock,
	input  logic reset,
	input  logic exu_valid,
	output logic exu_ready,
	input  core_pkg::decoded_t decoded,
	output logic mem_valid,
	input  logic mem_ready,
	output core_pkg::memory_request_t request,
	output core_pkg::stage_status_t exu_status,
	output logic redirect,
	output core_pkg::word_t redirect_pc
);

	core_pkg::word_t link;
	core_pkg::word_t result;
	core_pkg::word_t next_pc;
	logic taken;
	logic accept;

	assign link = decoded.pc + 32'd4;

	always_comb begin
		if (decoded.opcode[core_pkg::op_lui]) begin
			result = decoded.imm;
		end else if (decoded.opcode[core_pkg::op_auipc]) begin
			result = decoded.pc + decoded.imm;
		end else if (decoded.opcode[core_pkg::op_jal] | decoded.opcode[core_pkg::op_jalr]) begin
			result = link;
		end else if (decoded.opcode[core_pkg::op_add]) begin
			result = decoded.src1 + decoded.src2;
		end else begin
			// addi, and the effective address for lw and sw.
			result = decoded.src1 + decoded.imm;
		end
	end

	// other branch encodings never take.
	assign taken = decoded.opcode[core_pkg::op_beq] & (decoded.funct3 == 3'b000) &
		(decoded.src1 == decoded.src2);

	always_comb begin
		if (decoded.opcode[core_pkg::op_jalr]) begin
			next_pc = (decoded.src1 + decoded.imm) & ~32'd1;
		end else if (decoded.opcode[core_pkg::op_jal] | taken) begin
			next_pc = decoded.pc + decoded.imm;
		end else begin
			next_pc = link;
		end
	end

	// nothing new comes in while the redirect is out.
	assign exu_ready = (~mem_valid | mem_ready) & ~redirect;
	assign accept = exu_valid & exu_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_valid <= 1'b0;
			redirect <= 1'b0;
		end else begin
			redirect <= accept & (next_pc != decoded.dnpc);
			if (accept) begin
				mem_valid <= 1'b1;
			end else if (mem_ready) begin
				mem_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			request.opcode <= decoded.opcode;
			request.rd <= decoded.rd;
			request.reg_wen <= decoded.reg_wen;
			request.result <= result;
			request.store_data <= decoded.src2;
			redirect_pc <= next_pc;
		end
	end

	assign exu_status.rd = request.rd;
	assign exu_status.reg_wen = request.reg_wen;
	assign exu_status.load = request.opcode[core_pkg::op_lw];
	assign exu_status.busy = mem_valid;
	assign exu_status.value = request.result;

endmodule

// ==== source/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit (
	input  logic clock,
	input  logic reset,
	input  logic mem_valid,
	output logic mem_ready,
	input  core_pkg::memory_request_t request,
	output core_pkg::stage_status_t mem_status,
	output logic write_enable,
	output core_pkg::reg_index_t write_rd,
	output core_pkg::word_t write_value,
	output logic retire_valid,
	output core_pkg::retire_t retire
);

	typedef enum logic {
		state_idle,
		state_access
	} state_e;

	state_e state;
	core_pkg::memory_request_t held;
	core_pkg::word_t dmem [core_pkg::DMEM_DEPTH];
	core_pkg::dmem_address_t dmem_index;
	core_pkg::word_t load_data;
	core_pkg::retire_t completed;
	logic is_memory_op;
	logic alu_done;
	logic access_done;

	assign mem_ready = (state == state_idle);
	assign is_memory_op = request.opcode[core_pkg::op_lw] | request.opcode[core_pkg::op_sw];
	// alu results pass straight through in the cycle they arrive.
	assign alu_done = mem_ready & mem_valid & ~is_memory_op;
	assign access_done = (state == state_access);

	assign dmem_index = core_pkg::dmem_address_t'(held.result >> 2);
	assign load_data = dmem[dmem_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
		end else if (access_done) begin
			state <= state_idle;
		end else if (mem_valid & is_memory_op) begin
			state <= state_access;
		end
	end

	always_ff @(posedge clock) begin
		if (mem_ready & mem_valid & is_memory_op) begin
			held <= request;
		end
		if (access_done & held.opcode[core_pkg::op_sw]) begin
			dmem[dmem_index] <= held.store_data;
		end
	end

	assign completed.rd = access_done ? held.rd : request.rd;
	assign completed.reg_wen = access_done ? held.reg_wen : request.reg_wen;
	assign completed.value = access_done ? load_data : request.result;

	assign write_enable = (alu_done | access_done) & completed.reg_wen;
	assign write_rd = completed.rd;
	assign write_value = completed.value;

	always_ff @(posedge clock) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= alu_done | access_done;
		end
	end

	always_ff @(posedge clock) begin
		retire <= completed;
	end

	// load data is read during the access cycle, so it is never pending here.
	assign mem_status.rd = held.rd;
	assign mem_status.reg_wen = held.reg_wen;
	assign mem_status.load = 1'b0;
	assign mem_status.busy = access_done;
	assign mem_status.value = load_data;

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input  logic clock,
	input  logic reset,
	input  logic run,
	input  logic imem_write,
	input  core_pkg::imem_address_t imem_address,
	input  core_pkg::word_t imem_data,
	output logic retire_valid,
	output core_pkg::retire_t retire
);

	logic fetch_valid;
	logic fetch_ready;
	core_pkg::fetch_packet_t fetch_packet;
	core_pkg::reg_index_t rs1;
	core_pkg::reg_index_t rs2;
	core_pkg::word_t src1;
	core_pkg::word_t src2;
	logic exu_valid;
	logic exu_ready;
	core_pkg::decoded_t decoded;
	logic mem_valid;
	logic mem_ready;
	core_pkg::memory_request_t request;
	core_pkg::stage_status_t exu_status;
	core_pkg::stage_status_t mem_status;
	logic redirect;
	core_pkg::word_t redirect_pc;
	logic write_enable;
	core_pkg::reg_index_t write_rd;
	core_pkg::word_t write_value;

	fetch_unit fetch_unit_inst (
		.clock(clock),
		.reset(reset),
		.run(run),
		.imem_write(imem_write),
		.imem_address(imem_address),
		.imem_data(imem_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fetch_ready(fetch_ready),
		.fetch_valid(fetch_valid),
		.fetch_packet(fetch_packet)
	);

	register_file register_file_inst (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.src1(src1),
		.src2(src2),
		.write_enable(write_enable),
		.write_rd(write_rd),
		.write_value(write_value)
	);

	decode_unit decode_unit_inst (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch_packet(fetch_packet),
		.rs1(rs1),
		.rs2(rs2),
		.src1(src1),
		.src2(src2),
		.exu_status(exu_status),
		.mem_status(mem_status),
		.redirect(redirect),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.decoded(decoded)
	);

	execute_unit execute_unit_inst (
		.clock(clock),
		.reset(reset),
		.exu_valid(exu_valid),
		.exu_ready(exu_ready),
		.decoded(decoded),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.request(request),
		.exu_status(exu_status),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	memory_unit memory_unit_inst (
		.clock(clock),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.request(request),
		.mem_status(mem_status),
		.write_enable(write_enable),
		.write_rd(write_rd),
		.write_value(write_value),
		.retire_valid(retire_valid),
		.retire(retire)
	);

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

	localparam int PROGRAM_COUNT = 12;
	localparam int PROGRAM_LENGTH = 40;
	localparam int RETIRE_TIMEOUT = 4000;
	localparam int K_ADD = 0;
	localparam int K_ADDI = 1;
	localparam int K_LUI = 2;
	localparam int K_AUIPC = 3;
	localparam int K_LW = 4;
	localparam int K_SW = 5;
	localparam int K_BEQ = 6;
	localparam int K_JAL = 7;
	localparam int K_JALR = 8;

	logic clock;
	logic reset;
	logic run;
	logic imem_write;
	core_pkg::imem_address_t imem_address;
	core_pkg::word_t imem_data;
	logic retire_valid;
	core_pkg::retire_t retire;

	logic [31:0] lfsr;
	core_pkg::word_t program_word [core_pkg::IMEM_DEPTH];
	int kind [core_pkg::IMEM_DEPTH];
	int rd_of [core_pkg::IMEM_DEPTH];
	int rs1_of [core_pkg::IMEM_DEPTH];
	int rs2_of [core_pkg::IMEM_DEPTH];
	core_pkg::word_t imm_of [core_pkg::IMEM_DEPTH];
	core_pkg::word_t model_regs [16];
	core_pkg::word_t model_dmem [core_pkg::DMEM_DEPTH];
	core_pkg::retire_t expected [$];
	core_pkg::retire_t halt_retire;
	core_pkg::retire_t want;
	int halt_index;
	int retired;
	int checks;
	int mismatches;
	int timeouts;
	logic checking;
	logic idle_check;
	logic ok;

	core_top core_top_inst (
		.clock(clock),
		.reset(reset),
		.run(run),
		.imem_write(imem_write),
		.imem_address(imem_address),
		.imem_data(imem_data),
		.retire_valid(retire_valid),
		.retire(retire)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit.
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < count; b++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return value;
	endfunction

	function automatic core_pkg::word_t encode_r(input int rd, input int rs1, input int rs2);
		return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
	endfunction

	function automatic core_pkg::word_t encode_i(input core_pkg::word_t imm, input int rs1,
		input logic [2:0] funct3, input int rd, input logic [6:0] opcode);
		return {imm[11:0], 5'(rs1), funct3, 5'(rd), opcode};
	endfunction

	function automatic core_pkg::word_t encode_s(input core_pkg::word_t imm, input int rs2,
		input int rs1);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic core_pkg::word_t encode_b(input core_pkg::word_t imm, input int rs2,
		input int rs1);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic core_pkg::word_t encode_u(input core_pkg::word_t imm, input int rd,
		input logic [6:0] opcode);
		return {imm[31:12], 5'(rd), opcode};
	endfunction

	function automatic core_pkg::word_t encode_j(input core_pkg::word_t imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic core_pkg::word_t encode_entry(input int i);
		case (kind[i])
			K_ADD: return encode_r(rd_of[i], rs1_of[i], rs2_of[i]);
			K_ADDI: return encode_i(imm_of[i], rs1_of[i], 3'b000, rd_of[i], 7'b0010011);
			K_LUI: return encode_u(imm_of[i], rd_of[i], 7'b0110111);
			K_AUIPC: return encode_u(imm_of[i], rd_of[i], 7'b0010111);
			K_LW: return encode_i(imm_of[i], rs1_of[i], 3'b010, rd_of[i], 7'b0000011);
			K_SW: return encode_s(imm_of[i], rs2_of[i], rs1_of[i]);
			K_BEQ: return encode_b(imm_of[i], rs2_of[i], rs1_of[i]);
			K_JAL: return encode_j(imm_of[i], rd_of[i]);
			default: return encode_i(imm_of[i], rs1_of[i], 3'b000, rd_of[i], 7'b1100111);
		endcase
	endfunction

	// jal x0, 0 parks the core; the words after it are harmless addi x0 fillers.
	task automatic place_halt_and_fill(input int length);
		for (int i = 0; i < length; i++) begin
			program_word[i] = encode_entry(i);
		end
		halt_index = length;
		program_word[length] = encode_j('0, 0);
		for (int a = length + 1; a < core_pkg::IMEM_DEPTH; a++) begin
			program_word[a] = encode_i(32'(a), 0, 3'b000, 0, 7'b0010011);
		end
	endtask

	// fills all sixteen data words that the random programs can reach.
	task automatic make_store_program();
		for (int k = 0; k < 16; k++) begin
			kind[2 * k] = K_ADDI;
			rd_of[2 * k] = 1;
			rs1_of[2 * k] = 0;
			rs2_of[2 * k] = 0;
			imm_of[2 * k] = 32'(17 * k + 5);
			kind[2 * k + 1] = K_SW;
			rd_of[2 * k + 1] = 0;
			rs1_of[2 * k + 1] = 0;
			rs2_of[2 * k + 1] = 1;
			imm_of[2 * k + 1] = 32'(4 * k);
		end
		place_halt_and_fill(32);
	endtask

	task automatic make_random_program();
		int pick;
		int last_rd;
		int target;
		logic follow_load;
		logic [31:0] bits;
		last_rd = 1;
		follow_load = 1'b0;
		for (int i = 0; i < PROGRAM_LENGTH; i++) begin
			pick = follow_load ? 9 : int'(take_bits(4));
			follow_load = 1'b0;
			rd_of[i] = int'(take_bits(3));
			rs1_of[i] = take_bits(1) ? last_rd : int'(take_bits(3));
			rs2_of[i] = take_bits(1) ? last_rd : int'(take_bits(3));
			target = i + 1 + int'(take_bits(3));
			if (target > PROGRAM_LENGTH) begin
				target = PROGRAM_LENGTH;
			end
			bits = take_bits(20);
			imm_of[i] = {{20{bits[11]}}, bits[11:0]};
			case (pick)
				0, 1, 2, 3: kind[i] = K_ADD;
				4, 5, 6: kind[i] = K_ADDI;
				7, 8: begin
					kind[i] = (pick == 7) ? K_LUI : K_AUIPC;
					imm_of[i] = {bits[19:0], 12'b0};
				end
				9, 10: begin
					// x15 is the only base and always holds a small multiple of four.
					kind[i] = (pick == 9) ? K_LW : K_SW;
					rs1_of[i] = 15;
					imm_of[i] = 32'(4 * bits[2:0]);
				end
				11: begin
					kind[i] = K_BEQ;
					imm_of[i] = 32'((target - i) * 4);
					if (bits[3]) begin
						rs2_of[i] = rs1_of[i];
					end
				end
				12: begin
					kind[i] = K_JAL;
					imm_of[i] = 32'((target - i) * 4);
				end
				13: begin
					kind[i] = K_JALR;
					rs1_of[i] = 0;
					imm_of[i] = 32'(target * 4);
				end
				default: begin
					kind[i] = K_ADDI;
					rd_of[i] = 15;
					rs1_of[i] = 0;
					imm_of[i] = 32'(4 * bits[2:0]);
					follow_load = (i + 1 < PROGRAM_LENGTH);
				end
			endcase
			if (kind[i] != K_SW && kind[i] != K_BEQ) begin
				last_rd = rd_of[i];
			end
		end
		place_halt_and_fill(PROGRAM_LENGTH);
	endtask

	// the ISA model follows the taken path only.
	task automatic run_model();
		core_pkg::word_t pc;
		core_pkg::word_t next_pc;
		core_pkg::word_t r1;
		core_pkg::word_t r2;
		core_pkg::word_t address;
		core_pkg::retire_t entry;
		int i;
		expected.delete();
		for (int r = 0; r < 16; r++) begin
			model_regs[r] = '0;
		end
		pc = '0;
		while (pc != 32'(halt_index * 4) && expected.size() < core_pkg::IMEM_DEPTH) begin
			i = int'(pc >> 2);
			r1 = model_regs[rs1_of[i]];
			r2 = model_regs[rs2_of[i]];
			address = r1 + imm_of[i];
			next_pc = pc + 32'd4;
			entry.rd = 4'(rd_of[i]);
			entry.reg_wen = 1'b1;
			entry.value = pc + 32'd4;
			case (kind[i])
				K_ADD: entry.value = r1 + r2;
				K_ADDI: entry.value = r1 + imm_of[i];
				K_LUI: entry.value = imm_of[i];
				K_AUIPC: entry.value = pc + imm_of[i];
				K_LW: entry.value = model_dmem[address[7:2]];
				K_SW: begin
					model_dmem[address[7:2]] = r2;
					entry.reg_wen = 1'b0;
				end
				K_BEQ: begin
					entry.reg_wen = 1'b0;
					if (r1 == r2) begin
						next_pc = pc + imm_of[i];
					end
				end
				K_JAL: next_pc = pc + imm_of[i];
				default: next_pc = address & ~32'd1;
			endcase
			if (entry.reg_wen && rd_of[i] != 0) begin
				model_regs[rd_of[i]] = entry.value;
			end
			expected.push_back(entry);
			pc = next_pc;
		end
		halt_retire.rd = '0;
		halt_retire.reg_wen = 1'b1;
		halt_retire.value = 32'(halt_index * 4 + 4);
	endtask

	task automatic load_program();
		for (int a = 0; a < core_pkg::IMEM_DEPTH; a++) begin
			@(posedge clock);
			imem_write <= 1'b1;
			imem_address <= core_pkg::imem_address_t'(a);
			imem_data <= program_word[a];
		end
		@(posedge clock);
		imem_write <= 1'b0;
	endtask

	task automatic execute_program(output logic finished);
		int cycles;
		run_model();
		@(posedge clock);
		reset <= 1'b1;
		checking = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		idle_check = 1'b1;
		load_program();
		@(posedge clock);
		idle_check = 1'b0;
		retired = 0;
		checking = 1'b1;
		run <= 1'b1;
		cycles = 0;
		// two halt retires show that nothing else follows the program.
		while (retired < expected.size() + 2 && cycles < RETIRE_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		run <= 1'b0;
		checking = 1'b0;
		finished = (retired >= expected.size() + 2);
		if (!finished) begin
			timeouts++;
			$display("timeout: only %0d of %0d expected retires arrived", retired,
				expected.size() + 2);
		end
	endtask

	always @(negedge clock) begin
		if (idle_check) begin
			assert (!retire_valid) else begin
				mismatches++;
				$display("Error at %0t: retire_valid is high while run is low", $time);
			end
		end
		if (checking && retire_valid) begin
			want = (retired < expected.size()) ? expected[retired] : halt_retire;
			assert (retire.reg_wen == want.reg_wen && (!want.reg_wen ||
				(retire.rd == want.rd && retire.value == want.value))) else begin
				mismatches++;
				$display("Error at %0t: retire %0d got x%0d/%0b/%h, want x%0d/%0b/%h",
					$time, retired, retire.rd, retire.reg_wen, retire.value,
					want.rd, want.reg_wen, want.value);
			end
			retired++;
			checks++;
		end
	end

	initial begin
		lfsr = 32'hda1b;
		reset = 1'b1;
		run = 1'b0;
		imem_write = 1'b0;
		imem_address = '0;
		imem_data = '0;
		checking = 1'b0;
		idle_check = 1'b0;
		retired = 0;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		make_store_program();
		execute_program(ok);
		for (int p = 0; p < PROGRAM_COUNT && ok; p++) begin
			make_random_program();
			execute_program(ok);
		end
		$display("%0d retires checked, %0d mismatches, %0d timeouts", checks, mismatches,
			timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
source/core_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/core_top.sv
test/core_tb.sv

// ==== build.sh ====
#!/bin/sh

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f build.f -o core_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
